//--- logic/fc_consts.svh
`ifndef FC_CONSTS_SVH
`define FC_CONSTS_SVH

// stream word layout
`define FC_LANES 4
`define FC_LANE_W 8
`define FC_WORD_W 32

// accumulator and reduced result width
`define FC_ACC_W 16

// feature memory
`define FC_DEPTH 64
`define FC_ADDR_W 6

// register stages in the partial-product multiplier
`define FC_MUL_LAT 8

`endif

//--- logic/fc_pkg.sv
`include "fc_consts.svh"

package fc_pkg;

  // one signed int8 operand
  typedef logic signed [`FC_LANE_W-1:0] lane_t;

  // stream word, raw for the SRAM or split per lane (lane 0 in the low byte)
  typedef union packed {
    logic [`FC_WORD_W-1:0]       raw;
    lane_t [`FC_LANES-1:0]       lane;
  } fc_word_u;

  typedef struct packed {
    logic     is_weight;  // 0 feature word, 1 weight word
    logic     last;       // closes the vector or the row
    fc_word_u word;
  } in_beat_t;

  // one lane pair for a multiply-accumulate element
  typedef struct packed {
    logic  valid;
    logic  first;  // clears the accumulator
    logic  last;
    lane_t feat;
    lane_t wgt;
  } pe_in_t;

  typedef logic signed [`FC_ACC_W-1:0] acc_t;

  typedef struct packed {
    acc_t sum;
    logic ovf;
  } fc_result_t;

endpackage

//--- logic/cla_adder16.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module cla_adder16 (
  input  logic [`FC_ACC_W-1:0] a,
  input  logic [`FC_ACC_W-1:0] b,
  output logic [`FC_ACC_W-1:0] sum,
  output logic                 ovf
);

  localparam int NG = `FC_ACC_W / 4;  // number of 4-bit groups

  logic [`FC_ACC_W-1:0] p;   // bit propagate
  logic [`FC_ACC_W-1:0] g;   // bit generate
  logic [`FC_ACC_W-1:0] c;   // carry into each bit
  logic [NG-1:0]        gp;  // group propagate
  logic [NG-1:0]        gg;  // group generate
  logic [NG:0]          gc;  // carry into each group, gc[NG] is the carry out

  assign p = a ^ b;
  assign g = a & b;

  //////////////////////////////////////////////////////////////////////
  // 4-bit lookahead groups
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NG; k++) begin : g_grp
    localparam int LO = 4 * k;

    assign gp[k] = &p[LO+3:LO];
    assign gg[k] = g[LO+3]
                 | (p[LO+3] & g[LO+2])
                 | (p[LO+3] & p[LO+2] & g[LO+1])
                 | (p[LO+3] & p[LO+2] & p[LO+1] & g[LO]);

    // bit carries inside the group, all from the group carry-in
    assign c[LO]   = gc[k];
    assign c[LO+1] = g[LO] | (p[LO] & gc[k]);
    assign c[LO+2] = g[LO+1]
                   | (p[LO+1] & g[LO])
                   | (p[LO+1] & p[LO] & gc[k]);
    assign c[LO+3] = g[LO+2]
                   | (p[LO+2] & g[LO+1])
                   | (p[LO+2] & p[LO+1] & g[LO])
                   | (p[LO+2] & p[LO+1] & p[LO] & gc[k]);
  end

  //////////////////////////////////////////////////////////////////////
  // group carry generator
  //////////////////////////////////////////////////////////////////////

  assign gc[0] = 1'b0;  // add only

  for (genvar k = 0; k < NG; k++) begin : g_clg
    assign gc[k+1] = gg[k] | (gp[k] & gc[k]);
  end

  assign sum = p ^ c;

  // signed wrap when carry into and out of the sign bit differ
  assign ovf = c[`FC_ACC_W-1] ^ gc[NG];

endmodule

//--- logic/pe_mac.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module pe_mac (
  input  logic           clk,
  input  logic           rstn,
  input  fc_pkg::pe_in_t pe_in,
  output fc_pkg::acc_t   acc,
  output logic           ovf,
  output logic           done
);

  import fc_pkg::*;

  localparam int LAT = `FC_MUL_LAT;

  logic [7:0]     a_mag, b_mag;
  logic [7:0]     pp [8];          // partial products of the magnitudes
  logic [7:0]     pp_r [8];
  logic [LAT-2:0] sign_p;          // product sign, stages 1 to 7
  logic [LAT-1:0] vld_p, first_p, last_p;
  logic [5:0]     lsb2 [4];
  logic [5:0]     lsb2_r [4];
  logic [2:0]     hi2a_r [4];
  logic [3:0]     hi2b_r [4];
  logic [4:0]     hi3 [4];
  logic [9:0]     sum3_r [4];
  logic [7:0]     lsb4 [2];
  logic [7:0]     lsb4_r [2];
  logic [2:0]     hi4a_r [2];
  logic [4:0]     hi4b_r [2];
  logic [4:0]     hi5 [2];
  logic [11:0]    sum5_r [2];
  logic [9:0]     lsb6, lsb6_r;
  logic [2:0]     hi6a_r;
  logic [6:0]     hi6b_r, hi7;
  logic [15:0]    mag_r;           // unsigned product
  acc_t           prod_r, acc_base, acc_nx;
  logic           add_ovf;

  // magnitudes, -128 maps to 8'h80
  assign a_mag = pe_in.feat[7] ? -pe_in.feat : pe_in.feat;
  assign b_mag = pe_in.wgt[7] ? -pe_in.wgt : pe_in.wgt;

  //////////////////////////////////////////////////////////////////////
  // split adder tree, low bits in one stage and high bits in the next
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? a_mag : 8'h00;
    end
    for (int j = 0; j < 4; j++) begin
      lsb2[j] = {1'b0, pp_r[2*j][4:0]} + {1'b0, pp_r[2*j+1][3:0], 1'b0};
      hi3[j]  = {2'b00, hi2a_r[j]} + {1'b0, hi2b_r[j]} + {4'b0000, lsb2_r[j][5]};
    end
    for (int k = 0; k < 2; k++) begin
      lsb4[k] = {1'b0, sum3_r[2*k][6:0]} + {1'b0, sum3_r[2*k+1][4:0], 2'b00};
      hi5[k]  = {2'b00, hi4a_r[k]} + hi4b_r[k] + {4'b0000, lsb4_r[k][7]};
    end
    lsb6 = {1'b0, sum5_r[0][8:0]} + {1'b0, sum5_r[1][4:0], 4'h0};
    hi7  = {4'h0, hi6a_r} + hi6b_r + {6'd0, lsb6_r[9]};
  end

  // stages run every cycle, valid rides alongside
  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      pp_r[i] <= pp[i];                                   // stage 1
    end
    sign_p <= {sign_p[LAT-3:0], pe_in.feat[7] ^ pe_in.wgt[7]};
    for (int j = 0; j < 4; j++) begin
      lsb2_r[j] <= lsb2[j];                               // stage 2
      hi2a_r[j] <= pp_r[2*j][7:5];
      hi2b_r[j] <= pp_r[2*j+1][7:4];
      sum3_r[j] <= {hi3[j], lsb2_r[j][4:0]};              // stage 3
    end
    for (int k = 0; k < 2; k++) begin
      lsb4_r[k] <= lsb4[k];                               // stage 4
      hi4a_r[k] <= sum3_r[2*k][9:7];
      hi4b_r[k] <= sum3_r[2*k+1][9:5];
      sum5_r[k] <= {hi5[k], lsb4_r[k][6:0]};              // stage 5
    end
    lsb6_r <= lsb6;                                       // stage 6
    hi6a_r <= sum5_r[0][11:9];
    hi6b_r <= sum5_r[1][11:5];
    mag_r  <= {hi7, lsb6_r[8:0]};                         // stage 7
    prod_r <= sign_p[LAT-2] ? -mag_r : mag_r;             // stage 8
  end

  //////////////////////////////////////////////////////////////////////
  // accumulate
  //////////////////////////////////////////////////////////////////////

  assign acc_base = first_p[LAT-1] ? '0 : acc;  // new row starts from zero

  cla_adder16 u_acc_add (
    .a   (prod_r),
    .b   (acc_base),
    .sum (acc_nx),
    .ovf (add_ovf)
  );

  always_ff @(posedge clk) begin
    if (vld_p[LAT-1]) begin
      acc <= acc_nx;
      ovf <= add_ovf | (ovf & ~first_p[LAT-1]);  // sticky over the row
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_p   <= '0;
      first_p <= '0;
      last_p  <= '0;
      done    <= 1'b0;
    end else begin
      vld_p   <= {vld_p[LAT-2:0], pe_in.valid};
      first_p <= {first_p[LAT-2:0], pe_in.first};
      last_p  <= {last_p[LAT-2:0], pe_in.last};
      done    <= vld_p[LAT-1] & last_p[LAT-1];
    end
  end

endmodule

//--- logic/feature_sram.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module feature_sram #(
  parameter int DEPTH = `FC_DEPTH,
  parameter int AW    = `FC_ADDR_W
) (
  input  logic                  clk,
  input  logic                  we,
  input  logic                  re,
  input  logic [AW-1:0]         addr,
  input  logic [`FC_WORD_W-1:0] wdata,
  output fc_pkg::fc_word_u      rdata
);

  logic [`FC_WORD_W-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    if (re) begin
      rdata.raw <= mem[addr];  // data back one cycle after the read
    end
  end

  // one port, so loads and weight reads must not collide
  a_one_port: assert property (@(posedge clk) !(we && re))
    else $error("feature_sram write and read in the same cycle");

endmodule

//--- logic/dot_ctrl.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module dot_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  in_stb,
  input  fc_pkg::in_beat_t      in_beat,
  output logic                  feat_done,
  output logic                  sram_we,
  output logic                  sram_re,
  output logic [`FC_ADDR_W-1:0] sram_addr,
  output logic [`FC_WORD_W-1:0] sram_wdata,
  input  fc_pkg::fc_word_u      sram_rdata,
  output fc_pkg::pe_in_t        pe_in [`FC_LANES]
);

  import fc_pkg::*;

  localparam int LW = `FC_ADDR_W + 1;  // holds a full count of DEPTH

  logic                  feat_beat, wgt_beat;
  logic [`FC_ADDR_W-1:0] wr_idx;    // next feature slot
  logic [`FC_ADDR_W-1:0] w_idx;     // weight index in the current row
  logic [LW-1:0]         feat_len;  // words in the stored vector
  logic [LW-1:0]         w_cnt;
  fc_word_u              wgt_q;     // weight word waiting for rdata
  logic                  vld_q, first_q, last_q;

  assign feat_beat = in_stb & ~in_beat.is_weight;
  assign wgt_beat  = in_stb & in_beat.is_weight;
  assign w_cnt     = {1'b0, w_idx} + LW'(1);

  assign sram_we    = feat_beat;
  assign sram_re    = wgt_beat;
  assign sram_addr  = feat_beat ? wr_idx : w_idx;
  assign sram_wdata = in_beat.word.raw;

  //////////////////////////////////////////////////////////////////////
  // indices and issue
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_idx    <= '0;
      w_idx     <= '0;
      feat_len  <= '0;
      feat_done <= 1'b0;
      vld_q     <= 1'b0;
      first_q   <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      feat_done <= feat_beat & in_beat.last;
      vld_q     <= wgt_beat;
      if (feat_beat) begin
        if (in_beat.last) begin
          wr_idx   <= '0;
          feat_len <= {1'b0, wr_idx} + LW'(1);  // latch length on the last word
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
      if (wgt_beat) begin
        first_q <= (w_idx == '0);
        last_q  <= in_beat.last;
        w_idx   <= in_beat.last ? '0 : w_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wgt_beat) begin
      wgt_q <= in_beat.word;  // lines up with the registered read
    end
  end

  always_comb begin
    for (int i = 0; i < `FC_LANES; i++) begin
      pe_in[i].valid = vld_q;
      pe_in[i].first = first_q;
      pe_in[i].last  = last_q;
      pe_in[i].feat  = sram_rdata.lane[i];
      pe_in[i].wgt   = wgt_q.lane[i];
    end
  end

  // a row closes exactly at the stored feature count
  a_row_len: assert property (@(posedge clk) disable iff (!rstn)
    wgt_beat |-> (in_beat.last == (w_cnt == feat_len)))
    else $error("weight row length differs from feature length");

endmodule

//--- logic/lane_reduce.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module lane_reduce (
  input  logic                 clk,
  input  logic                 rstn,
  input  fc_pkg::acc_t         acc [`FC_LANES],
  input  logic [`FC_LANES-1:0] ovf,
  input  logic                 done,
  output logic                 res_stb,
  output fc_pkg::fc_result_t   res
);

  import fc_pkg::*;

  acc_t sum_lo, sum_hi, sum_all;
  logic ovf_lo, ovf_hi, ovf_all;

  //////////////////////////////////////////////////////////////////////
  // two-level adder tree
  //////////////////////////////////////////////////////////////////////

  cla_adder16 u_add_lo (
    .a   (acc[0]),
    .b   (acc[1]),
    .sum (sum_lo),
    .ovf (ovf_lo)
  );

  cla_adder16 u_add_hi (
    .a   (acc[2]),
    .b   (acc[3]),
    .sum (sum_hi),
    .ovf (ovf_hi)
  );

  cla_adder16 u_add_all (
    .a   (sum_lo),
    .b   (sum_hi),
    .sum (sum_all),
    .ovf (ovf_all)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      res_stb <= 1'b0;
    end else begin
      res_stb <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      res.sum <= sum_all;
      res.ovf <= (|ovf) | ovf_lo | ovf_hi | ovf_all;  // any lane or tree wrap
    end
  end

endmodule

//--- logic/fc_dot_top.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module fc_dot_top (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_stb,
  input  fc_pkg::in_beat_t   in_beat,
  output logic               feat_done,
  output logic               res_stb,
  output fc_pkg::fc_result_t res
);

  import fc_pkg::*;

  logic                  sram_we, sram_re;
  logic [`FC_ADDR_W-1:0] sram_addr;
  logic [`FC_WORD_W-1:0] sram_wdata;
  fc_word_u              sram_rdata;
  pe_in_t                pe_in [`FC_LANES];
  acc_t                  lane_acc [`FC_LANES];
  logic [`FC_LANES-1:0]  lane_ovf;
  logic                  lane_done;  // from lane 0 only

  dot_ctrl u_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .in_stb     (in_stb),
    .in_beat    (in_beat),
    .feat_done  (feat_done),
    .sram_we    (sram_we),
    .sram_re    (sram_re),
    .sram_addr  (sram_addr),
    .sram_wdata (sram_wdata),
    .sram_rdata (sram_rdata),
    .pe_in      (pe_in)
  );

  feature_sram #(.DEPTH(`FC_DEPTH), .AW(`FC_ADDR_W)) u_sram (
    .clk   (clk),
    .we    (sram_we),
    .re    (sram_re),
    .addr  (sram_addr),
    .wdata (sram_wdata),
    .rdata (sram_rdata)
  );

  for (genvar l = 0; l < `FC_LANES; l++) begin : g_pe
    if (l == 0) begin : g_lead
      pe_mac u_pe (
        .clk   (clk),
        .rstn  (rstn),
        .pe_in (pe_in[l]),
        .acc   (lane_acc[l]),
        .ovf   (lane_ovf[l]),
        .done  (lane_done)
      );
    end else begin : g_follow
      pe_mac u_pe (
        .clk   (clk),
        .rstn  (rstn),
        .pe_in (pe_in[l]),
        .acc   (lane_acc[l]),
        .ovf   (lane_ovf[l]),
        .done  ()           // same cycle as lane 0
      );
    end
  end

  lane_reduce u_reduce (
    .clk     (clk),
    .rstn    (rstn),
    .acc     (lane_acc),
    .ovf     (lane_ovf),
    .done    (lane_done),  // lanes finish together
    .res_stb (res_stb),
    .res     (res)
  );

endmodule

//--- bench/fc_dot_checks.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module fc_dot_checks (
  input  logic               clk,
  input  logic               rstn,
  input  logic               in_stb,
  input  fc_pkg::in_beat_t   in_beat,
  input  logic               feat_done,
  input  logic               res_stb,
  input  fc_pkg::fc_result_t res,
  output int                 errors,
  output int                 checks,
  output int                 pending
);

  import fc_pkg::*;

  fc_word_u    feat_mem [`FC_DEPTH];  // model copy of the stored vector
  fc_result_t  exp_q [$];
  fc_result_t  exp_r;
  int          lane_sum [`FC_LANES];
  int          f_idx, w_idx, s, lo, hi, tot;
  logic        row_ovf, feat_end, row_end, feat_end_d;
  logic [10:0] row_pipe;              // last weight beats, 11 cycles back
  int          err_feat = 0;
  int          err_res = 0;
  int          err_rst = 0;
  int          err_val = 0;

  assign feat_end = in_stb & ~in_beat.is_weight & in_beat.last;
  assign row_end  = in_stb & in_beat.is_weight & in_beat.last;
  assign errors   = err_feat + err_res + err_rst + err_val;

  // wrap to the signed 16-bit accumulator range
  function automatic int to_acc(input int v);
    shortint t;
    t = shortint'(v);
    return int'(t);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      f_idx = 0;
      w_idx = 0;
      exp_q.delete();
    end else begin
      if (res_stb) begin
        if (exp_q.size() == 0) begin
          err_val++;
          $display("result strobe at %0t with no row outstanding", $time);
        end else begin
          exp_r = exp_q.pop_front();
          checks <= checks + 1;
          a_sum: assert (res.sum == exp_r.sum)
            else begin
              err_val++;
              $display("Fail t=%0t res.sum expected %0d got %0d", $time, exp_r.sum, res.sum);
            end
          a_ovf: assert (res.ovf == exp_r.ovf)
            else begin
              err_val++;
              $display("Fail t=%0t res.ovf expected %0b got %0b", $time, exp_r.ovf, res.ovf);
            end
        end
      end
      if (in_stb && !in_beat.is_weight) begin
        feat_mem[f_idx] = in_beat.word;
        f_idx = in_beat.last ? 0 : f_idx + 1;
      end
      if (in_stb && in_beat.is_weight) begin
        if (w_idx == 0) begin
          row_ovf = 1'b0;  // new row
        end
        for (int i = 0; i < `FC_LANES; i++) begin
          s = (w_idx == 0 ? 0 : lane_sum[i])
            + int'($signed(feat_mem[w_idx].lane[i])) * int'($signed(in_beat.word.lane[i]));
          lane_sum[i] = to_acc(s);
          row_ovf = row_ovf | (lane_sum[i] != s);
        end
        if (in_beat.last) begin
          lo  = lane_sum[0] + lane_sum[1];
          hi  = lane_sum[2] + lane_sum[3];
          tot = to_acc(lo) + to_acc(hi);
          exp_r.sum = acc_t'(tot);
          exp_r.ovf = row_ovf | (to_acc(lo) != lo) | (to_acc(hi) != hi) | (to_acc(tot) != tot);
          exp_q.push_back(exp_r);
          w_idx = 0;
        end else begin
          w_idx++;
        end
      end
    end
    pending <= exp_q.size();
  end

  //////////////////////////////////////////////////////////////////////
  // strobe timing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      feat_end_d <= 1'b0;
      row_pipe   <= '0;
    end else begin
      feat_end_d <= feat_end;
      row_pipe   <= {row_pipe[9:0], row_end};
    end
  end

  a_feat_done: assert property (@(posedge clk) disable iff (!rstn) feat_done == feat_end_d)
    else begin
      err_feat++;
      $display("Fail t=%0t feat_done expected %0b got %0b",
               $time, $sampled(feat_end_d), $sampled(feat_done));
    end

  a_res_stb: assert property (@(posedge clk) disable iff (!rstn) res_stb == row_pipe[10])
    else begin
      err_res++;
      $display("Fail t=%0t res_stb expected %0b got %0b",
               $time, $sampled(row_pipe[10]), $sampled(res_stb));
    end

  a_quiet_rst: assert property (@(posedge clk) (!rstn && $past(!rstn)) |-> !(feat_done || res_stb))
    else begin
      err_rst++;
      $display("feat_done or res_stb went high during reset at %0t", $time);
    end

endmodule

//--- bench/tb_fc_dot.sv
`timescale 1ns/10ps
`include "fc_consts.svh"

module tb_fc_dot;

  import fc_pkg::*;

  logic       clk;
  logic       rstn;
  logic       in_stb;
  in_beat_t   in_beat;
  logic       feat_done;
  logic       res_stb;
  fc_result_t res;

  logic [`FC_WORD_W-1:0] words [16];  // staged vector for the next send
  int n_words;
  int beats = 0;
  int rows = 0;
  int cycles = 0;
  int tb_errors = 0;
  int chk_errors, checks, pending;

  fc_dot_top u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .in_stb    (in_stb),
    .in_beat   (in_beat),
    .feat_done (feat_done),
    .res_stb   (res_stb),
    .res       (res)
  );

  fc_dot_checks u_chk (
    .clk       (clk),
    .rstn      (rstn),
    .in_stb    (in_stb),
    .in_beat   (in_beat),
    .feat_done (feat_done),
    .res_stb   (res_stb),
    .res       (res),
    .errors    (chk_errors),
    .checks    (checks),
    .pending   (pending)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // budget grows with every beat issued
  initial begin
    while (cycles < 1000 + 200 * beats) begin
      @(posedge clk);
      cycles++;
    end
    $display("watchdog expired after %0d cycles", cycles);
    $display("Checks failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic void fill_small_words(input int n);
    for (int i = 0; i < n; i++) begin
      for (int l = 0; l < `FC_LANES; l++) begin
        words[i][8*l +: 8] = 8'($urandom % 16) - 8'd8;  // lanes in -8..7
      end
    end
  endfunction

  function automatic void fill_const_words(input int n, input logic [`FC_WORD_W-1:0] w);
    for (int i = 0; i < n; i++) begin
      words[i] = w;
    end
  endfunction

  task automatic drive_beat(input logic is_w, input logic last, input logic [31:0] w);
    @(posedge clk);
    in_stb            <= 1'b1;
    in_beat.is_weight <= is_w;
    in_beat.last      <= last;
    in_beat.word.raw  <= w;
    beats++;
  endtask

  task automatic go_idle();
    @(posedge clk);
    in_stb  <= 1'b0;
    in_beat <= '0;
  endtask

  task automatic send_vector(input logic is_w, input int n);
    for (int i = 0; i < n; i++) begin
      drive_beat(is_w, i == n - 1, words[i]);
    end
    if (is_w) begin
      rows++;
    end
  endtask

  // send staged words as features, then wait for the load strobe
  task automatic load_features(input int n);
    int wait_cnt;
    wait_cnt = 0;
    send_vector(1'b0, n);
    go_idle();
    while (!feat_done && wait_cnt < 8) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!feat_done) begin
      tb_errors++;
      $display("no feat_done after feature load at %0t", $time);
    end
  endtask

  task automatic send_rows(input int n, input int count);
    for (int r = 0; r < count; r++) begin
      fill_small_words(n);
      send_vector(1'b1, n);  // rows follow each other with no gap
    end
  endtask

  task automatic wait_results();
    int wait_cnt;
    wait_cnt = 0;
    while (pending != 0 && wait_cnt < 40) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (pending != 0) begin
      tb_errors++;
      $display("%0d results still outstanding at %0t", pending, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'hea33));
    rstn    = 1'b0;
    in_stb  = 1'b0;
    in_beat = '0;
    repeat (8) @(posedge clk);
    rstn <= 1'b1;
    repeat (12) @(posedge clk);  // quiet window before stimulus

    // random vectors, back-to-back rows on each
    for (int v = 0; v < 4; v++) begin
      n_words = 4 + int'($urandom % 13);
      fill_small_words(n_words);
      load_features(n_words);
      send_rows(n_words, 3);
      go_idle();
      wait_results();
    end

    // -128 * -128 over two words wraps each lane
    fill_const_words(2, 32'h8080_8080);
    load_features(2);
    send_vector(1'b1, 2);
    send_rows(2, 1);  // in range again
    go_idle();
    wait_results();

    // new features loaded while the last row is still in flight
    n_words = 8;
    fill_small_words(n_words);
    load_features(n_words);
    send_rows(n_words, 1);
    fill_small_words(n_words);
    load_features(n_words);
    send_rows(n_words, 2);
    go_idle();
    wait_results();

    repeat (4) @(posedge clk);
    if (checks != rows) begin
      tb_errors++;
      $display("%0d rows sent but %0d results checked", rows, checks);
    end
    $display("results %0d, checker errors %0d, bench errors %0d", checks, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+logic
logic/fc_pkg.sv
logic/cla_adder16.sv
logic/pe_mac.sv
logic/feature_sram.sv
logic/dot_ctrl.sv
logic/lane_reduce.sv
logic/fc_dot_top.sv
bench/fc_dot_checks.sv
bench/tb_fc_dot.sv

//--- Makefile
SRCS := $(shell grep -v '^+' tb.f)

obj_dir/Vtb_fc_dot: tb.f $(SRCS) logic/fc_consts.svh
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_fc_dot -o Vtb_fc_dot

run: obj_dir/Vtb_fc_dot
	./obj_dir/Vtb_fc_dot | tee sim.log
	grep -q "^All checks passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
